//--- i3c_target_pkg.sv
/*
 * Shared types for the I3C/I2C target front end.
 * Only 7-bit addressing is supported, and 10-bit I2C addresses are not.
 * The bus-free count is in system clock cycles, up to 20 bits.
 */

package i3c_target_pkg;

  // Widths with a meaning on the bus or the register port
  typedef logic [6:0]  addr7_t;
  typedef logic [7:0]  addr_byte_t;
  typedef logic [19:0] cnt_t;
  typedef logic [1:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  typedef enum logic {
    MODE_I2C = 1'b0,
    MODE_I3C = 1'b1
  } bus_mode_e;

  typedef struct packed {
    logic      enable;
    bus_mode_e mode;
    addr7_t    sta_addr;
    addr7_t    dyn_addr;
    logic      dyn_addr_valid;
    cnt_t      t_bus_free;
  } target_cfg_t;

  // One-cycle pulses, except sda_sampled which is a level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda_sampled;
  } bus_event_t;

  localparam addr7_t BROADCAST_ADDR = 7'h7E;

  // Register map
  localparam cfg_addr_t REG_CTRL     = 2'd0;
  localparam cfg_addr_t REG_STA_ADDR = 2'd1;
  localparam cfg_addr_t REG_DYN_ADDR = 2'd2;
  localparam cfg_addr_t REG_BUS_FREE = 2'd3;

endpackage

//--- target_config.sv
/*
 * Write-only configuration registers for the target front end.
 * A write is visible on cfg_o in the cycle after the strobe edge.
 * All fields clear on reset, which leaves the block disabled.
 */

`timescale 1ns/1ns

module target_config
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        cfg_we_i,
  input  cfg_addr_t   cfg_addr_i,
  input  cfg_data_t   cfg_wdata_i,

  output target_cfg_t cfg_o
);

  target_cfg_t cfg_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        REG_CTRL: begin
          cfg_q.enable <= cfg_wdata_i[0];
          cfg_q.mode   <= bus_mode_e'(cfg_wdata_i[1]);
        end
        REG_STA_ADDR: begin
          cfg_q.sta_addr <= cfg_wdata_i[6:0];
        end
        REG_DYN_ADDR: begin
          cfg_q.dyn_addr       <= cfg_wdata_i[6:0];
          cfg_q.dyn_addr_valid <= cfg_wdata_i[7];
        end
        REG_BUS_FREE: begin
          cfg_q.t_bus_free <= cfg_wdata_i[19:0];
        end
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // A valid dynamic address in I3C mode must never alias the broadcast address
  property dyn_addr_not_broadcast_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      (cfg_we_i && cfg_addr_i == REG_DYN_ADDR && cfg_wdata_i[7] && cfg_q.mode == MODE_I3C)
      |=> !(cfg_q.dyn_addr_valid && cfg_q.dyn_addr == BROADCAST_ADDR);
  endproperty

  dyn_addr_not_broadcast_a: assert property (dyn_addr_not_broadcast_p)
    else $error("dynamic address set to broadcast address in I3C mode");

endmodule

//--- bus_cond_detect.sv
/*
 * Synchronizes SCL/SDA and reports START, repeated START and STOP.
 * Event pulses are registered and appear SyncStages + 1 cycles after the pad change.
 * SyncStages must be 2 or more. No glitch filter is applied to the pads.
 */

`timescale 1ns/1ns

module bus_cond_detect
  import i3c_target_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        scl_i,
  input  logic        sda_i,

  input  target_cfg_t cfg_i,

  output bus_event_t  event_o,
  output logic        bus_idle_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_prev_q;
  logic                  sda_prev_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  start_c;
  logic                  rstart_c;
  logic                  stop_c;
  logic                  busy_q;
  bus_event_t            event_q;
  cnt_t                  free_cnt_q;
  logic                  idle_q;
  logic                  start_seen_q;

  // Bus lines idle high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // SDA edges while SCL is high
  assign start_c  = cfg_i.enable && scl_s && scl_prev_q && sda_prev_q && !sda_s && !busy_q;
  assign rstart_c = cfg_i.enable && scl_s && scl_prev_q && sda_prev_q && !sda_s && busy_q;
  assign stop_c   = cfg_i.enable && scl_s && scl_prev_q && !sda_prev_q && sda_s;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (!cfg_i.enable || stop_c) begin
      busy_q <= 1'b0;
    end else if (start_c) begin
      busy_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      event_q             <= '0;
      event_q.sda_sampled <= 1'b1;
    end else begin
      event_q.start       <= start_c;
      event_q.rstart      <= rstart_c;
      event_q.stop        <= stop_c;
      event_q.scl_rise    <= cfg_i.enable && scl_s && !scl_prev_q;
      event_q.scl_fall    <= cfg_i.enable && !scl_s && scl_prev_q;
      event_q.sda_sampled <= sda_s;
    end
  end

  // Bus-free timer counts only while not inside a transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      free_cnt_q <= '0;
      idle_q     <= 1'b0;
    end else if (!cfg_i.enable || busy_q || !(scl_s && sda_s)) begin
      free_cnt_q <= '0;
      idle_q     <= 1'b0;
    end else if (free_cnt_q >= cfg_i.t_bus_free) begin
      idle_q <= 1'b1;
    end else begin
      free_cnt_q <= free_cnt_q + 1'b1;
    end
  end

  assign event_o    = event_q;
  assign bus_idle_o = idle_q;

  // Transfer window as seen from the reported START and STOP pulses
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_seen_q <= 1'b0;
    end else if (!cfg_i.enable || event_q.stop) begin
      start_seen_q <= 1'b0;
    end else if (event_q.start) begin
      start_seen_q <= 1'b1;
    end
  end

  conditions_exclusive_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({event_q.start, event_q.rstart, event_q.stop})
  ) else $error("more than one bus condition in one cycle");

  rstart_while_busy_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      event_q.rstart |-> start_seen_q
  ) else $error("repeated START reported outside a transfer");

endmodule

//--- addr_capture.sv
/*
 * Captures the first byte after START or repeated START and ACKs a matching address.
 * SDA is open-drain only, sda_o high means released.
 * Bytes after the address are ignored until the next bus condition.
 */

`timescale 1ns/1ns

module addr_capture
  import i3c_target_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  target_cfg_t cfg_i,
  input  bus_event_t  event_i,

  output addr_byte_t  bus_addr_o,
  output logic        bus_addr_valid_o,
  output logic        addr_ack_o,
  output logic        sda_o
);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    ACK,
    WAIT_STOP
  } state_e;

  state_e     state_q;
  logic [2:0] bit_cnt_q;
  logic [6:0] shift_q;
  addr_byte_t addr_q;
  addr_byte_t byte_c;
  logic       valid_q;
  logic       ack_q;
  logic       sda_q;

  function automatic logic addr_match(target_cfg_t cfg, addr7_t addr);
    logic hit;
    if (cfg.mode == MODE_I2C) begin
      hit = (addr == cfg.sta_addr);
    end else begin
      hit = (addr == BROADCAST_ADDR) || (cfg.dyn_addr_valid && addr == cfg.dyn_addr);
    end
    return hit;
  endfunction

  // Completed byte, valid on the scl_rise of the eighth bit
  assign byte_c = {shift_q, event_i.sda_sampled};

  always_ff @(posedge clk_i) begin
    if (state_q == SHIFT && event_i.scl_rise) begin
      shift_q <= byte_c[6:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      addr_q    <= '0;
      valid_q   <= 1'b0;
      ack_q     <= 1'b0;
      sda_q     <= 1'b1;
    end else begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
      if (!cfg_i.enable || event_i.stop) begin
        state_q <= IDLE;
        sda_q   <= 1'b1;
      end else if (event_i.start || event_i.rstart) begin
        state_q   <= SHIFT;
        bit_cnt_q <= '0;
        sda_q     <= 1'b1;
      end else begin
        case (state_q)
          SHIFT: begin
            if (event_i.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                addr_q  <= byte_c;
                valid_q <= 1'b1;
                if (addr_match(cfg_i, byte_c[7:1])) begin
                  ack_q   <= 1'b1;
                  state_q <= ACK;
                end else begin
                  state_q <= WAIT_STOP;
                end
              end
            end
          end
          ACK: begin
            // First fall starts the ACK bit, second fall ends it
            if (event_i.scl_fall) begin
              if (sda_q) begin
                sda_q <= 1'b0;
              end else begin
                sda_q   <= 1'b1;
                state_q <= WAIT_STOP;
              end
            end
          end
          default: begin
            state_q <= state_q;
          end
        endcase
      end
    end
  end

  assign bus_addr_o       = addr_q;
  assign bus_addr_valid_o = valid_q;
  assign addr_ack_o       = ack_q;
  assign sda_o            = sda_q;

  sda_low_only_in_ack_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      !sda_q |-> state_q == ACK
  ) else $error("SDA pulled low outside the ACK slot");

endmodule

//--- i3c_target_ctrl.sv
/*
 * Target-side bus front end: configuration, bus conditions and address capture.
 * SCL is input only, SDA is open-drain with sda_o high meaning released.
 * No handshakes, every output is a level or a one-cycle pulse.
 */

`timescale 1ns/1ns

module i3c_target_ctrl
  import i3c_target_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Pads
  input  logic       scl_i,
  input  logic       sda_i,
  output logic       sda_o,

  // Register write port
  input  logic       cfg_we_i,
  input  cfg_addr_t  cfg_addr_i,
  input  cfg_data_t  cfg_wdata_i,

  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output addr_byte_t bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       addr_ack_o,
  output logic       bus_idle_o
);

  target_cfg_t target_cfg;
  bus_event_t  bus_event;

  target_config u_target_config (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .cfg_o      (target_cfg)
  );

  bus_cond_detect #(
    .SyncStages(SyncStages)
  ) u_bus_cond_detect (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .scl_i     (scl_i),
    .sda_i     (sda_i),
    .cfg_i     (target_cfg),
    .event_o   (bus_event),
    .bus_idle_o(bus_idle_o)
  );

  addr_capture u_addr_capture (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cfg_i           (target_cfg),
    .event_i         (bus_event),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .addr_ack_o      (addr_ack_o),
    .sda_o           (sda_o)
  );

  assign bus_start_o  = bus_event.start;
  assign bus_rstart_o = bus_event.rstart;
  assign bus_stop_o   = bus_event.stop;

endmodule

//--- tb_bus_tasks.svh
/*
 * Bit-banged bus tasks, included inside the testbench module.
 * Every task starts and ends right after a rising clock edge.
 * SCL half periods are 16 clocks, and SDA changes halfway through SCL low.
 */

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int HalfPeriod = 16;

task automatic hold_clocks(input int n);
  repeat (n) @(posedge clk_i);
endtask

// Bus idle high on entry, SCL low on exit
task automatic send_start();
  sda_i <= 1'b0;
  hold_clocks(HalfPeriod);
  scl_i <= 1'b0;
  hold_clocks(HalfPeriod / 2);
endtask

// Entered with SCL low after the ACK slot
task automatic send_rstart();
  sda_i <= 1'b1;
  hold_clocks(HalfPeriod / 2);
  scl_i <= 1'b1;
  hold_clocks(HalfPeriod);
  sda_i <= 1'b0;
  hold_clocks(HalfPeriod);
  scl_i <= 1'b0;
  hold_clocks(HalfPeriod / 2);
endtask

task automatic send_stop();
  sda_i <= 1'b0;
  hold_clocks(HalfPeriod / 2);
  scl_i <= 1'b1;
  hold_clocks(HalfPeriod);
  sda_i <= 1'b1;
  hold_clocks(HalfPeriod);
endtask

task automatic send_bit(input logic b);
  sda_i <= b;
  hold_clocks(HalfPeriod / 2);
  scl_i <= 1'b1;
  hold_clocks(HalfPeriod);
  scl_i <= 1'b0;
  hold_clocks(HalfPeriod / 2);
endtask

// MSB first
task automatic send_byte(input logic [7:0] data);
  for (int i = 7; i >= 0; i--) begin
    send_bit(data[i]);
  end
endtask

// Ninth clock with SDA released, target drive sampled mid SCL high
task automatic ack_slot(output logic pulled_low);
  sda_i <= 1'b1;
  hold_clocks(HalfPeriod / 2);
  scl_i <= 1'b1;
  hold_clocks(HalfPeriod / 2);
  @(negedge clk_i);
  pulled_low = !sda_o;
  hold_clocks(HalfPeriod / 2);
  scl_i <= 1'b0;
  hold_clocks(HalfPeriod / 2);
endtask

`endif

//--- tb_i3c_target_ctrl.sv
/*
 * Testbench for the target front end, driven from i3c_target_stim.txt.
 * The SDA pad is not modelled as a wired AND, so sda_o is only observed.
 * Expected ACK and idle values come from the stimulus file.
 */

`timescale 1ns/1ns

module tb_i3c_target_ctrl
  import i3c_target_pkg::*;
();

  localparam int StimWords = 256;
  localparam int WaitLimit = 200;
  localparam int EvStart   = 0;
  localparam int EvRstart  = 1;
  localparam int EvStop    = 2;
  localparam int EvValid   = 3;
  localparam int EvAck     = 4;

  logic       clk_i;
  logic       rst_n_i;
  logic       scl_i;
  logic       sda_i;
  logic       cfg_we_i;
  cfg_addr_t  cfg_addr_i;
  cfg_data_t  cfg_wdata_i;
  logic       sda_o;
  logic       bus_start_o;
  logic       bus_rstart_o;
  logic       bus_stop_o;
  addr_byte_t bus_addr_o;
  logic       bus_addr_valid_o;
  logic       addr_ack_o;
  logic       bus_idle_o;

  logic [31:0] stim_mem [0:StimWords-1];
  logic [31:0] op;
  logic [31:0] arg0;
  logic [31:0] arg1;
  logic [31:0] arg2;
  int          ev_cnt [0:4];
  int          exp_cnt [0:4];
  addr_byte_t  last_addr;
  logic        last_ack;
  logic        sda_low_seen;
  logic        enabled;
  logic        running;
  int          errors;
  int          timeouts;
  int          op_pos;
  int          n_ops;
  int unsigned rnd_seed;
  int unsigned gap;

  i3c_target_ctrl #(
    .SyncStages(2)
  ) uut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .sda_o           (sda_o),
    .cfg_we_i        (cfg_we_i),
    .cfg_addr_i      (cfg_addr_i),
    .cfg_wdata_i     (cfg_wdata_i),
    .bus_start_o     (bus_start_o),
    .bus_rstart_o    (bus_rstart_o),
    .bus_stop_o      (bus_stop_o),
    .bus_addr_o      (bus_addr_o),
    .bus_addr_valid_o(bus_addr_valid_o),
    .addr_ack_o      (addr_ack_o),
    .bus_idle_o      (bus_idle_o)
  );

  always #4 clk_i = ~clk_i;

  `include "tb_bus_tasks.svh"

  // Pulses are sampled mid cycle
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (bus_start_o) ev_cnt[EvStart] = ev_cnt[EvStart] + 1;
      if (bus_rstart_o) ev_cnt[EvRstart] = ev_cnt[EvRstart] + 1;
      if (bus_stop_o) ev_cnt[EvStop] = ev_cnt[EvStop] + 1;
      if (addr_ack_o) ev_cnt[EvAck] = ev_cnt[EvAck] + 1;
      if (bus_addr_valid_o) begin
        ev_cnt[EvValid] = ev_cnt[EvValid] + 1;
        last_addr = bus_addr_o;
        last_ack  = addr_ack_o;
      end
      if (!sda_o) sda_low_seen = 1'b1;
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic string count_name(input int sel);
    string name;
    case (sel)
      EvStart:  name = "START";
      EvRstart: name = "repeated START";
      EvStop:   name = "STOP";
      EvValid:  name = "address capture";
      default:  name = "address ACK";
    endcase
    return name;
  endfunction

  task automatic wait_count(input int sel);
    int n;
    n = 0;
    while (ev_cnt[sel] < exp_cnt[sel] && n < WaitLimit) begin
      @(posedge clk_i);
      n++;
    end
    if (ev_cnt[sel] < exp_cnt[sel]) begin
      $display("Timed out at %0t waiting for a %s pulse", $time, count_name(sel));
      timeouts++;
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < 5; i++) begin
      if (ev_cnt[i] != exp_cnt[i]) begin
        report_error($sformatf("%0d %s pulses, expected %0d",
                               ev_cnt[i], count_name(i), exp_cnt[i]));
      end
    end
  endtask

  task automatic write_reg(input cfg_addr_t idx, input cfg_data_t data);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= idx;
    cfg_wdata_i <= data;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic run_transfer(input logic rep, input addr_byte_t data,
                              input logic exp_ack, input logic do_stop);
    logic pulled_low;
    sda_low_seen = 1'b0;
    if (rep) begin
      send_rstart();
    end else begin
      send_start();
    end
    if (enabled) begin
      exp_cnt[rep ? EvRstart : EvStart]++;
      wait_count(rep ? EvRstart : EvStart);
    end
    @(negedge clk_i);
    if (bus_idle_o !== 1'b0) report_error("bus_idle_o still high after START");
    @(posedge clk_i);
    send_byte(data);
    if (enabled) begin
      exp_cnt[EvValid]++;
      if (exp_ack) exp_cnt[EvAck]++;
      wait_count(EvValid);
      if (last_addr !== data) begin
        report_error($sformatf("bus_addr_o is %h, expected %h", last_addr, data));
      end
      if (last_ack !== exp_ack) begin
        report_error($sformatf("addr_ack_o is %b for byte %h, expected %b",
                               last_ack, data, exp_ack));
      end
    end
    ack_slot(pulled_low);
    if (pulled_low !== exp_ack) begin
      report_error($sformatf("SDA low in ninth clock is %b for byte %h, expected %b",
                             pulled_low, data, exp_ack));
    end
    if (!exp_ack && sda_low_seen) report_error("sda_o pulled low without an ACK");
    if (do_stop) begin
      send_stop();
      if (enabled) begin
        exp_cnt[EvStop]++;
        wait_count(EvStop);
      end
    end
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    scl_i        = 1'b1;
    sda_i        = 1'b1;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    errors       = 0;
    timeouts     = 0;
    enabled      = 1'b0;
    sda_low_seen = 1'b0;
    last_addr    = '0;
    last_ack     = 1'b0;
    for (int i = 0; i < 5; i++) begin
      ev_cnt[i]  = 0;
      exp_cnt[i] = 0;
    end
    for (int i = 0; i < StimWords; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("i3c_target_stim.txt", stim_mem);
    rnd_seed = 32'h7f47c353;
    gap      = $urandom(rnd_seed);

    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    if (sda_o !== 1'b1) report_error("sda_o not released after reset");
    if (bus_idle_o !== 1'b0) report_error("bus_idle_o high after reset");
    if (bus_addr_valid_o !== 1'b0 || addr_ack_o !== 1'b0) begin
      report_error("address pulses active after reset");
    end
    @(posedge clk_i);

    op_pos  = 0;
    n_ops   = 0;
    running = 1'b1;
    while (running && op_pos + 3 < StimWords) begin
      op   = stim_mem[op_pos];
      arg0 = stim_mem[op_pos + 1];
      arg1 = stim_mem[op_pos + 2];
      arg2 = stim_mem[op_pos + 3];
      case (op)
        32'd0: running = 1'b0;
        32'd1: begin
          write_reg(arg0[1:0], arg1);
          if (arg0[1:0] == REG_CTRL) enabled = arg1[0];
        end
        32'd2: begin
          gap = 16 + ($urandom % 32);
          hold_clocks(gap);
          run_transfer(1'b0, arg0[7:0], arg1[0], arg2[0]);
        end
        32'd3: run_transfer(1'b1, arg0[7:0], arg1[0], arg2[0]);
        32'd4: begin
          hold_clocks(arg0);
          @(negedge clk_i);
          if (bus_idle_o !== arg1[0]) begin
            report_error($sformatf("bus_idle_o is %b, expected %b", bus_idle_o, arg1[0]));
          end
          @(posedge clk_i);
        end
        default: begin
          $display("Unknown opcode %0h in the stimulus file at word %0d", op, op_pos);
          errors++;
          running = 1'b0;
        end
      endcase
      if (running) n_ops++;
      check_counts();
      op_pos += 4;
    end
    if (n_ops == 0) begin
      $display("No operations were read from the stimulus file");
      errors++;
    end

    hold_clocks(4);
    $display("Closing report: %0d errors, %0d timeouts, %0d operations",
             errors, timeouts, n_ops);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- i3c_target_stim.txt
// Columns (hex): opcode arg0 arg1 arg2
// 1 cfg write: index data - | 2 START+byte: byte ack stop | 3 rSTART+byte: byte ack stop | 4 idle wait: cycles idle - | 0 end
2 A0 0 1   // still disabled, no events and SDA released
1 1 50 0   // static address 0x50
1 3 64 0   // bus-free count 100
1 0 1 0    // enable, I2C mode
2 A0 1 0   // 0x50 write, kept for repeated START
3 A1 1 1   // 0x50 read, then STOP
4 14 0 0   // not yet free
4 64 1 0   // past the bus-free time
2 A2 0 1   // 0x51 not ours
2 FD 0 1   // broadcast means nothing in I2C
1 0 3 0    // enable, I3C mode
2 FC 1 1   // broadcast write
2 A0 0 1   // static address ignored in I3C
1 2 32 0   // dynamic address 0x32, not valid yet
2 64 0 0   // 0x32 write, no ACK
3 FD 1 1   // broadcast read after repeated START
1 2 B2 0   // dynamic address 0x32 marked valid
2 65 1 1   // 0x32 read
4 14 0 0
4 64 1 0
2 64 1 1   // 0x32 write after idle
0 0 0 0

//--- i3c_target_ctrl.f
+incdir+.
i3c_target_pkg.sv
target_config.sv
bus_cond_detect.sv
addr_capture.sv
i3c_target_ctrl.sv
tb_i3c_target_ctrl.sv

//--- Bender.yml
package:
  name: i3c_target_ctrl

sources:
  - i3c_target_pkg.sv
  - target_config.sv
  - bus_cond_detect.sv
  - addr_capture.sv
  - i3c_target_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i3c_target_ctrl.sv
